// File: run.sh
#!/bin/sh
# build and run with Verilator, the log decides the result
verilator --binary --timing --assert -f sim.f --top-module vid_split_tb \
  -o vid_split_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/vid_split_sim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1
grep -q "TESTBENCH PASSED" sim.log || { echo "simulation ended without a pass"; exit 1; }
exit 0

// File: sim.f
verilog/vid_split_pkg.sv
verilog/vid_split_fp.sv
verilog/vid_split_wide.sv
verilog/vid_split_cfg.sv
verilog/vid_split_ctrl.sv
verilog/vid_split_top.sv
test/vid_split_clkgen.sv
test/vid_split_checker.sv
test/vid_split_tb.sv

// File: test/vid_split_checker.sv
module vid_split_checker
  import vid_split_pkg::*;
#(
  parameter int INST_WIDTH = INST_WIDTH_DEF
) (
  input logic                  split_clk,
  input logic                  cpurst_b,
  input logic                  async_flush,
  input logic                  dis_stall,
  input logic                  dis_uop_vld,
  input logic [INST_WIDTH-1:0] dis_uop_data,
  input logic                  ex1_stall
);

  timeunit 1ns;
  timeprecision 1ps;

  // ------------------------------
  // upstream stall
  // ------------------------------
  // nothing held in or just out of reset
  a_stall_low_rst: assert property (
    @(posedge split_clk) (!cpurst_b || $rose(cpurst_b)) |-> !ex1_stall
  ) else $error("ex1_stall high in or right after reset");

  // ------------------------------
  // dispatch side
  // ------------------------------
  // stalled uop must not move, flush may drop it
  a_uop_hold: assert property (
    @(posedge split_clk) disable iff (!cpurst_b)
    (dis_uop_vld && dis_stall && !async_flush) |=> $stable(dis_uop_data)
  ) else $error("dis_uop_data changed while dispatch was stalled");

  // second uop is always the last one
  a_idx_last: assert property (
    @(posedge split_clk) disable iff (!cpurst_b)
    (dis_uop_vld && dis_uop_data[INST_WIDTH-IDX_OFS]) |-> dis_uop_data[INST_WIDTH-LAST_OFS]
  ) else $error("uop index set without the last flag");

endmodule

bind vid_split_top vid_split_checker #(.INST_WIDTH(INST_WIDTH)) u_checker (
  .split_clk    (split_clk),
  .cpurst_b     (cpurst_b),
  .async_flush  (async_flush),
  .dis_stall    (dis_stall),
  .dis_uop_vld  (dis_uop_vld),
  .dis_uop_data (dis_uop_data),
  .ex1_stall    (ex1_stall)
);

// File: test/vid_split_clkgen.sv
module vid_split_clkgen #(
  parameter int PERIOD_NS = 100
) (
  output logic split_clk
);

  timeunit 1ns;
  timeprecision 1ps;

  // free running, starts low
  initial
  begin
    split_clk = 1'b0;
    forever
      #(PERIOD_NS / 2) split_clk = ~split_clk;
  end

endmodule

// File: test/vid_split_tb.sv
module vid_split_tb
  import vid_split_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int W  = INST_WIDTH_DEF;
  localparam int N1 = 40;
  localparam int N2 = 40;
  localparam int N3 = 200;
  localparam int N4 = 60;
  localparam int N5 = 200;
  // generous margin over the traffic cycles
  localparam int CYCLE_LIMIT = (N1 + N2 + N3 + N4 + N5) * 4;

  logic                      split_clk;
  logic                      cpurst_b;
  logic                      async_flush;
  logic                      ex1_inst_vld;
  logic [W-1:0]              ex1_inst_data;
  logic                      dis_stall;
  logic                      cfg_wen;
  logic [CFG_ADDR_WIDTH-1:0] cfg_addr;
  logic [31:0]               cfg_wdata;
  logic                      ex1_stall;
  logic                      dis_uop_vld;
  logic [W-1:0]              dis_uop_data;
  logic [31:0]               cfg_rdata;

  // model state
  logic [W-1:0] exp_q[$];
  logic         en_model;
  int           split_cnt_model;
  logic [15:0]  lfsr;
  int           err_cnt = 0;
  int           tests_pass = 0;
  int           tests_fail = 0;
  int           cycle_cnt = 0;

  vid_split_clkgen u_clkgen (
    .split_clk (split_clk)
  );

  vid_split_top #(.INST_WIDTH(W)) vid_split_top_inst (
    .split_clk     (split_clk),
    .cpurst_b      (cpurst_b),
    .async_flush   (async_flush),
    .ex1_inst_vld  (ex1_inst_vld),
    .ex1_inst_data (ex1_inst_data),
    .dis_stall     (dis_stall),
    .cfg_wen       (cfg_wen),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .ex1_stall     (ex1_stall),
    .dis_uop_vld   (dis_uop_vld),
    .dis_uop_data  (dis_uop_data),
    .cfg_rdata     (cfg_rdata)
  );

  // ------------------------------
  // random source
  // ------------------------------
  // 16 bit fibonacci with taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // type on top, random dst, flags and payload below
  function automatic logic [W-1:0] make_inst(input logic [1:0] typ);
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand_bits(6);
    lo = rand_bits(32);
    return {typ, hi[5:0], lo};
  endfunction

  // ------------------------------
  // reference model
  // ------------------------------
  task automatic push_expected(input logic [W-1:0] inst);
    logic [W-1:0] u;
    u = inst;
    u[W-IDX_OFS] = 1'b0;
    if ((inst[W-TYPE_OFS -: TYPE_W] == SPLIT_WIDE) && en_model)
    begin
      // first half, more to come
      u[W-LAST_OFS] = 1'b0;
      exp_q.push_back(u);
      // second half writes the next register
      u[W-DST_OFS -: DST_W] = u[W-DST_OFS -: DST_W] + 5'd1;
      u[W-IDX_OFS]          = 1'b1;
    end
    u[W-LAST_OFS] = 1'b1;
    exp_q.push_back(u);
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
    if (exp !== got)
    begin
      $display("mismatch %s exp 0x%0h got 0x%0h", name, exp, got);
      err_cnt++;
    end
  endtask

  // ------------------------------
  // one clock of traffic
  // ------------------------------
  // kind 0 non or reserved, 1 wide, 2 any type
  task automatic run_cycle(input int kind, input logic send_en, input logic stall_en,
                           input logic flush_en);
    logic [31:0]  r;
    logic [1:0]   typ;
    logic [W-1:0] inst;
    logic         flush;
    logic         send;
    @(negedge split_clk);
    // a held entry shows up as upstream stall
    compare_value("ex1_stall", 64'(exp_q.size() != 0), 64'(ex1_stall));
    r = rand_bits(2);
    typ = r[1:0];
    if (kind == 0 && typ == 2'd1)
      typ = 2'd0;
    else if (kind == 1)
      typ = 2'd1;
    inst  = make_inst(typ);
    flush = flush_en && (rand_bits(4) == 0);
    send  = send_en && !ex1_stall && !flush && (rand_bits(2) != 0);
    async_flush   = flush;
    ex1_inst_vld  = send;
    ex1_inst_data = inst;
    // flush cycle keeps dispatch stalled so nothing is taken
    dis_stall = flush || (stall_en && (rand_bits(4) < 5));
    if (flush)
      exp_q.delete();
    if (send)
      push_expected(inst);
    #25;
    if (!flush)
    begin
      compare_value("dis_uop_vld", 64'(exp_q.size() != 0), 64'(dis_uop_vld));
      if (dis_uop_vld && !dis_stall && exp_q.size() != 0)
      begin
        compare_value("dis_uop_data", 64'(exp_q[0]), 64'(dis_uop_data));
        // second half taken means a split completed
        if (exp_q[0][W-IDX_OFS])
          split_cnt_model++;
        void'(exp_q.pop_front());
      end
    end
  endtask

  // let every pending uop go out, then one quiet cycle
  task automatic drain_pending();
    while (exp_q.size() != 0)
      run_cycle(0, 1'b0, 1'b0, 1'b0);
    run_cycle(0, 1'b0, 1'b0, 1'b0);
  endtask

  // ------------------------------
  // config port
  // ------------------------------
  task automatic write_cfg(input logic [CFG_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    @(negedge split_clk);
    ex1_inst_vld = 1'b0;
    cfg_wen      = 1'b1;
    cfg_addr     = addr;
    cfg_wdata    = data;
    @(negedge split_clk);
    cfg_wen = 1'b0;
  endtask

  task automatic read_cfg(input logic [CFG_ADDR_WIDTH-1:0] addr, input string name,
                          input logic [31:0] exp);
    @(negedge split_clk);
    ex1_inst_vld = 1'b0;
    cfg_addr     = addr;
    #25;
    compare_value(name, 64'(exp), 64'(cfg_rdata));
  endtask

  task automatic report_test(input int num, input string what, input int err_before);
    if (err_cnt == err_before)
    begin
      $display("test %0d %s: ok", num, what);
      tests_pass++;
    end
    else
    begin
      $display("test %0d %s: %0d errors", num, what, err_cnt - err_before);
      tests_fail++;
    end
  endtask

  // ------------------------------
  // watchdog
  // ------------------------------
  always @(posedge split_clk)
  begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT)
    begin
      $display("timeout, run exceeded %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    int err_before;
    lfsr            = 16'd24;
    en_model        = 1'b1;
    split_cnt_model = 0;
    cpurst_b        = 1'b0;
    async_flush     = 1'b0;
    ex1_inst_vld    = 1'b0;
    ex1_inst_data   = '0;
    dis_stall       = 1'b0;
    cfg_wen         = 1'b0;
    cfg_addr        = CFG_ADDR_CTRL;
    cfg_wdata       = 32'd0;
    // five rising edges in reset, release on the falling edge after
    repeat (5) @(posedge split_clk);
    @(negedge split_clk);
    cpurst_b = 1'b1;

    err_before = err_cnt;
    repeat (N1) run_cycle(0, 1'b1, 1'b0, 1'b0);
    drain_pending();
    report_test(1, "non-split and reserved", err_before);

    err_before = err_cnt;
    repeat (N2) run_cycle(1, 1'b1, 1'b0, 1'b0);
    drain_pending();
    report_test(2, "widening split", err_before);

    err_before = err_cnt;
    repeat (N3) run_cycle(2, 1'b1, 1'b1, 1'b0);
    drain_pending();
    report_test(3, "random dispatch stall", err_before);

    // counter so far, then clear
    err_before = err_cnt;
    read_cfg(CFG_ADDR_CNT, "split_cnt", 32'(split_cnt_model));
    write_cfg(CFG_ADDR_CNT, 32'd0);
    split_cnt_model = 0;
    read_cfg(CFG_ADDR_CNT, "split_cnt", 32'd0);
    repeat (N4 / 2) run_cycle(1, 1'b1, 1'b1, 1'b0);
    drain_pending();
    read_cfg(CFG_ADDR_CNT, "split_cnt", 32'(split_cnt_model));
    // chicken bit off so wide goes as one uop
    write_cfg(CFG_ADDR_CTRL, 32'd0);
    en_model = 1'b0;
    read_cfg(CFG_ADDR_CTRL, "split_wide_en", 32'd0);
    repeat (N4 / 2) run_cycle(1, 1'b1, 1'b1, 1'b0);
    drain_pending();
    read_cfg(CFG_ADDR_CNT, "split_cnt", 32'(split_cnt_model));
    write_cfg(CFG_ADDR_CNT, 32'd0);
    split_cnt_model = 0;
    read_cfg(CFG_ADDR_CNT, "split_cnt", 32'd0);
    write_cfg(CFG_ADDR_CTRL, 32'd1);
    en_model = 1'b1;
    report_test(4, "split enable and counter", err_before);

    err_before = err_cnt;
    repeat (N5) run_cycle(2, 1'b1, 1'b1, 1'b1);
    drain_pending();
    report_test(5, "random flush", err_before);

    $display("tests passed %0d failed %0d", tests_pass, tests_fail);
    if (tests_fail == 0 && err_cnt == 0)
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// File: verilog/vid_split_cfg.sv
module vid_split_cfg
  import vid_split_pkg::*;
(
  input  logic                      split_clk,
  input  logic                      cpurst_b,
  input  logic                      cfg_wen,
  input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [31:0]               cfg_wdata,
  input  logic                      split_done,
  output logic                      split_wide_en,
  output logic [31:0]               cfg_rdata
);

  logic        ctrl_wen;
  logic        cnt_clr;
  logic [31:0] split_cnt;

  // ------------------------------
  // write decode
  // ------------------------------
  assign ctrl_wen = cfg_wen && (cfg_addr == CFG_ADDR_CTRL);
  // any write to the count address clears it
  assign cnt_clr  = cfg_wen && (cfg_addr == CFG_ADDR_CNT);

  // chicken bit, splitting on out of reset
  always_ff @(posedge split_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      split_wide_en <= 1'b1;
    else if (ctrl_wen)
      split_wide_en <= cfg_wdata[0];
  end

  // completed widening splits
  always_ff @(posedge split_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      split_cnt <= 32'd0;
    else if (cnt_clr)
      split_cnt <= 32'd0;
    else if (split_done)
      split_cnt <= split_cnt + 32'd1;
  end

  // ------------------------------
  // read mux
  // ------------------------------
  always_comb
  begin
    case (cfg_addr)
      CFG_ADDR_CTRL: cfg_rdata = {31'd0, split_wide_en};
      CFG_ADDR_CNT:  cfg_rdata = split_cnt;
      default:       cfg_rdata = 32'd0;
    endcase
  end

endmodule

// File: verilog/vid_split_ctrl.sv
module vid_split_ctrl
  import vid_split_pkg::*;
#(
  parameter int INST_WIDTH = INST_WIDTH_DEF
) (
  input  logic                  ex1_inst_vld,
  input  logic [INST_WIDTH-1:0] ex1_inst_data,
  input  logic                  fp_uop_vld,
  input  logic [INST_WIDTH-1:0] fp_uop_data,
  input  logic                  fp_entry_vld,
  input  logic                  wide_uop_vld,
  input  logic [INST_WIDTH-1:0] wide_uop_data,
  input  logic                  wide_entry_vld,
  output logic                  dis_uop_vld,
  output logic [INST_WIDTH-1:0] dis_uop_data,
  output logic                  ex1_stall
);

  split_type_e in_type;
  logic        new_wide;
  logic        wide_pick;

  // ------------------------------
  // path select
  // ------------------------------
  assign in_type = split_type_e'(ex1_inst_data[INST_WIDTH-TYPE_OFS -: TYPE_W]);

  // type only steers the mux here
  always_comb
  begin
    case (in_type)
      SPLIT_WIDE:           new_wide = ex1_inst_vld;
      SPLIT_NON, SPLIT_RSV: new_wide = 1'b0;
      default:              new_wide = 1'b0;
    endcase
  end

  // a held entry wins over new input
  always_comb
  begin
    if (wide_entry_vld)
      wide_pick = 1'b1;
    else if (fp_entry_vld)
      wide_pick = 1'b0;
    else
      wide_pick = new_wide;
  end

  // ------------------------------
  // dispatch and upstream stall
  // ------------------------------
  assign dis_uop_vld  = wide_pick ? wide_uop_vld : fp_uop_vld;
  assign dis_uop_data = wide_pick ? wide_uop_data : fp_uop_data;

  // upstream waits while either splitter holds
  assign ex1_stall = fp_entry_vld || wide_entry_vld;

endmodule

// File: verilog/vid_split_fp.sv
module vid_split_fp
  import vid_split_pkg::*;
#(
  parameter int INST_WIDTH = INST_WIDTH_DEF
) (
  input  logic                  split_clk,
  input  logic                  cpurst_b,
  input  logic                  async_flush,
  input  logic                  ex1_inst_vld,
  input  logic [INST_WIDTH-1:0] ex1_inst_data,
  input  logic                  dis_stall,
  output logic                  uop_vld,
  output logic [INST_WIDTH-1:0] uop_data,
  output logic                  entry_vld
);

  split_type_e           in_type;
  split_state_e          cur_state;
  split_state_e          next_state;
  logic                  fp_sel;
  logic                  buf_wen;
  logic [INST_WIDTH-1:0] buf_data;
  logic [INST_WIDTH-1:0] src_data;

  // ------------------------------
  // input decode
  // ------------------------------
  assign in_type = split_type_e'(ex1_inst_data[INST_WIDTH-TYPE_OFS -: TYPE_W]);
  // non and both reserved codes take this path
  assign fp_sel  = ex1_inst_vld && (in_type != SPLIT_WIDE);

  // ------------------------------
  // hold fsm
  // ------------------------------
  always_ff @(posedge split_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= ST_IDLE;
    else if (async_flush)
      cur_state <= ST_IDLE;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    case (cur_state)
      ST_IDLE:
        next_state = (fp_sel && dis_stall) ? ST_HOLD : ST_IDLE;
      ST_HOLD:
        next_state = dis_stall ? ST_HOLD : ST_IDLE;
      default:
        next_state = ST_IDLE;
    endcase
  end

  assign entry_vld = (cur_state == ST_HOLD);

  // capture only when the first try is stalled
  assign buf_wen = (cur_state == ST_IDLE) && fp_sel && dis_stall;

  always_ff @(posedge split_clk)
  begin
    if (buf_wen)
      buf_data <= ex1_inst_data;
  end

  // ------------------------------
  // uop out
  // ------------------------------
  // replay from buffer while held
  assign src_data = entry_vld ? buf_data : ex1_inst_data;
  assign uop_vld  = entry_vld || fp_sel;

  always_comb
  begin
    uop_data = src_data;
    // single uop so index 0 and last set
    uop_data[INST_WIDTH-IDX_OFS]  = 1'b0;
    uop_data[INST_WIDTH-LAST_OFS] = 1'b1;
  end

endmodule

// File: verilog/vid_split_pkg.sv
package vid_split_pkg;

  // ------------------------------
  // instruction split types
  // ------------------------------
  // encoding 3 is left unnamed and decodes as non-split
  typedef enum logic [1:0] {
    SPLIT_NON  = 2'd0,
    SPLIT_WIDE = 2'd1,
    SPLIT_RSV  = 2'd2
  } split_type_e;

  // ------------------------------
  // split machine states
  // ------------------------------
  typedef enum logic [1:0] {
    ST_IDLE   = 2'd0,
    ST_HOLD   = 2'd1,
    ST_SECOND = 2'd2
  } split_state_e;

  // default instruction width
  localparam int INST_WIDTH_DEF = 40;

  // uop fields, counted down from the msb
  // with the default width they land on 39:38, 37:33, 32 and 31
  // the bits below the last flag are payload
  localparam int TYPE_OFS = 1;
  localparam int TYPE_W   = 2;
  localparam int DST_OFS  = 3;
  localparam int DST_W    = 5;
  localparam int IDX_OFS  = 8;
  localparam int LAST_OFS = 9;

  // config register map
  localparam int CFG_ADDR_WIDTH = 4;
  localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ADDR_CTRL = 4'd0;
  localparam logic [CFG_ADDR_WIDTH-1:0] CFG_ADDR_CNT  = 4'd1;

endpackage

// File: verilog/vid_split_top.sv
module vid_split_top
  import vid_split_pkg::*;
#(
  parameter int INST_WIDTH = INST_WIDTH_DEF
) (
  input  logic                      split_clk,
  input  logic                      cpurst_b,
  input  logic                      async_flush,
  input  logic                      ex1_inst_vld,
  input  logic [INST_WIDTH-1:0]     ex1_inst_data,
  input  logic                      dis_stall,
  input  logic                      cfg_wen,
  input  logic [CFG_ADDR_WIDTH-1:0] cfg_addr,
  input  logic [31:0]               cfg_wdata,
  output logic                      ex1_stall,
  output logic                      dis_uop_vld,
  output logic [INST_WIDTH-1:0]     dis_uop_data,
  output logic [31:0]               cfg_rdata
);

  logic                  split_wide_en;
  logic                  split_done;
  logic                  fp_uop_vld;
  logic [INST_WIDTH-1:0] fp_uop_data;
  logic                  fp_entry_vld;
  logic                  wide_uop_vld;
  logic [INST_WIDTH-1:0] wide_uop_data;
  logic                  wide_entry_vld;

  // ------------------------------
  // config block
  // ------------------------------
  vid_split_cfg u_cfg (
    .split_clk     (split_clk),
    .cpurst_b      (cpurst_b),
    .cfg_wen       (cfg_wen),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .split_done    (split_done),
    .split_wide_en (split_wide_en),
    .cfg_rdata     (cfg_rdata)
  );

  // ------------------------------
  // splitters
  // ------------------------------
  // both see the same ex1 instruction and dispatch stall
  vid_split_fp #(.INST_WIDTH(INST_WIDTH)) u_fp (
    .split_clk     (split_clk),
    .cpurst_b      (cpurst_b),
    .async_flush   (async_flush),
    .ex1_inst_vld  (ex1_inst_vld),
    .ex1_inst_data (ex1_inst_data),
    .dis_stall     (dis_stall),
    .uop_vld       (fp_uop_vld),
    .uop_data      (fp_uop_data),
    .entry_vld     (fp_entry_vld)
  );

  vid_split_wide #(.INST_WIDTH(INST_WIDTH)) u_wide (
    .split_clk     (split_clk),
    .cpurst_b      (cpurst_b),
    .async_flush   (async_flush),
    .ex1_inst_vld  (ex1_inst_vld),
    .ex1_inst_data (ex1_inst_data),
    .dis_stall     (dis_stall),
    .split_wide_en (split_wide_en),
    .uop_vld       (wide_uop_vld),
    .uop_data      (wide_uop_data),
    .entry_vld     (wide_entry_vld),
    .split_done    (split_done)
  );

  // ------------------------------
  // dispatch select
  // ------------------------------
  vid_split_ctrl #(.INST_WIDTH(INST_WIDTH)) u_ctrl (
    .ex1_inst_vld   (ex1_inst_vld),
    .ex1_inst_data  (ex1_inst_data),
    .fp_uop_vld     (fp_uop_vld),
    .fp_uop_data    (fp_uop_data),
    .fp_entry_vld   (fp_entry_vld),
    .wide_uop_vld   (wide_uop_vld),
    .wide_uop_data  (wide_uop_data),
    .wide_entry_vld (wide_entry_vld),
    .dis_uop_vld    (dis_uop_vld),
    .dis_uop_data   (dis_uop_data),
    .ex1_stall      (ex1_stall)
  );

endmodule

// File: verilog/vid_split_wide.sv
module vid_split_wide
  import vid_split_pkg::*;
#(
  parameter int INST_WIDTH = INST_WIDTH_DEF
) (
  input  logic                  split_clk,
  input  logic                  cpurst_b,
  input  logic                  async_flush,
  input  logic                  ex1_inst_vld,
  input  logic [INST_WIDTH-1:0] ex1_inst_data,
  input  logic                  dis_stall,
  input  logic                  split_wide_en,
  output logic                  uop_vld,
  output logic [INST_WIDTH-1:0] uop_data,
  output logic                  entry_vld,
  output logic                  split_done
);

  split_type_e           in_type;
  split_state_e          cur_state;
  split_state_e          next_state;
  logic                  wide_sel;
  logic                  buf_wen;
  logic                  hold_single;
  logic                  split_now;
  logic [INST_WIDTH-1:0] buf_data;
  logic [INST_WIDTH-1:0] src_data;
  logic [DST_W-1:0]      dst_next;

  // ------------------------------
  // input decode
  // ------------------------------
  assign in_type  = split_type_e'(ex1_inst_data[INST_WIDTH-TYPE_OFS -: TYPE_W]);
  assign wide_sel = ex1_inst_vld && (in_type == SPLIT_WIDE);

  // ------------------------------
  // split fsm
  // ------------------------------
  always_ff @(posedge split_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= ST_IDLE;
    else if (async_flush)
      cur_state <= ST_IDLE;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      ST_IDLE:
        if (wide_sel && dis_stall)
          next_state = ST_HOLD;
        else if (wide_sel && split_wide_en)
          next_state = ST_SECOND;
      ST_HOLD:
        // single uop mode returns straight to idle
        if (!dis_stall)
          next_state = hold_single ? ST_IDLE : ST_SECOND;
      ST_SECOND:
        if (!dis_stall)
          next_state = ST_IDLE;
      default:
        next_state = ST_IDLE;
    endcase
  end

  assign entry_vld = (cur_state != ST_IDLE);

  // enable bit sampled once per instruction
  always_ff @(posedge split_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      hold_single <= 1'b0;
    else if (buf_wen)
      hold_single <= !split_wide_en;
  end

  // second uop always needs the buffer, so capture every new one
  assign buf_wen = (cur_state == ST_IDLE) && wide_sel;

  always_ff @(posedge split_clk)
  begin
    if (buf_wen)
      buf_data <= ex1_inst_data;
  end

  // ------------------------------
  // uop out
  // ------------------------------
  assign src_data  = entry_vld ? buf_data : ex1_inst_data;
  assign uop_vld   = entry_vld || wide_sel;
  assign split_now = (cur_state == ST_IDLE) ? split_wide_en : !hold_single;
  // wraps at 32 registers
  assign dst_next  = src_data[INST_WIDTH-DST_OFS -: DST_W] + 5'd1;

  always_comb
  begin
    uop_data = src_data;
    uop_data[INST_WIDTH-IDX_OFS] = 1'b0;
    if (cur_state == ST_SECOND)
    begin
      // second half writes the next register
      uop_data[INST_WIDTH-DST_OFS -: DST_W] = dst_next;
      uop_data[INST_WIDTH-IDX_OFS]          = 1'b1;
      uop_data[INST_WIDTH-LAST_OFS]         = 1'b1;
    end
    else
      uop_data[INST_WIDTH-LAST_OFS] = !split_now;
  end

  // one pulse as the second uop is taken
  assign split_done = (cur_state == ST_SECOND) && !dis_stall;

endmodule
